// ==== sim/excUpdate_stimulus.txt ====
// record count, then per record: gainPitch gainCode sharpMin sharpMax subframeBase length codeBase
// expected sharp, exc words, code words, expected exc words after the run (length each)
6
// pitch gain above sharpMax, normal update
7000 0800 0CCD 6666 0100 0003 0200
6666
0100 FF00 1000
0400 0200 F000
00000240 FFFFFE80 00001A00
// maximum magnitudes and gains, saturation both ways
7FFF 7FFF 0CCD 6666 0300 0002 0380
6666
7FFF 8000
7FFF 8000
00007FFF FFFF8000
// pitch gain below sharpMin
0400 1000 0CCD 6666 0400 0002 0480
0CCD
2000 E000
0300 0010
000002C0 FFFFFE04
// in range, round up from one half
4000 2000 0CCD 6666 0500 0001 0580
4000
0001
0001
00000002
// zero length, gain equal to sharpMin
0CCD 0100 0CCD 6666 0600 0000 0680
0CCD
// gain equal to sharpMax
6666 0100 0CCD 6666 0700 0001 0780
6666
0010
0000
0000001A

// ==== excUpdate.f ====
rtl/excUpdatePkg.sv
rtl/basicOps.sv
rtl/longShifter.sv
rtl/scratchMemory.sv
rtl/excitationUpdate.sv
rtl/excUpdateTop.sv
sim/clockGen.sv
sim/excUpdate_props.sv
sim/excUpdateTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the excitation update testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert --top-module excUpdateTb -f excUpdate.f -o excUpdateSim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/excUpdateSim > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== sim/excUpdateTb.sv ====
module excUpdateTb;
	import excUpdatePkg::*;

	logic clock;
	logic reset;
	logic start;
	codecParams_t params;
	memRequest_t hostRequest;
	word32 hostData;
	logic busy;
	logic done;
	word16 sharp;

	// flat word image of the stimulus file, record count first
	logic [31:0] stimulus [0:255];
	logic [31:0] lfsrState;
	int pointer;

	clockGen #(
		.period(40),
		.resetCycles(5)
	) clockGen_i (
		.clock(clock),
		.reset(reset)
	);

	excUpdateTop #(
		.addrWidth(12)
	) excUpdateTop_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.params(params),
		.hostRequest(hostRequest),
		.hostData(hostData),
		.busy(busy),
		.done(done),
		.sharp(sharp)
	);

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stopWithFailure($sformatf("** Error at time %0t: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	//////////////////////////////
	// helpers
	//////////////////////////////

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// guard contents depend on every address bit
	function automatic word32 guardWord(input logic [15:0] address);
		return {address, ~address};
	endfunction

	function automatic word32 signExtend(input logic [31:0] w);
		return {{16{w[15]}}, w[15:0]};
	endfunction

	// 0..3 idle cycles from one lfsr step per bit
	task automatic idleGap();
		int cycles;
		cycles = 0;
		repeat (2)
		begin
			lfsrState = nextLfsr(lfsrState);
			cycles = cycles * 2 + int'(lfsrState[0]);
		end
		repeat (cycles) @(negedge clock);
	endtask

	task automatic hostWrite(input logic [15:0] address, input word32 data);
		@(negedge clock);
		hostRequest.writeEnable = 1'b1;
		hostRequest.address = address;
		hostRequest.data = data;
		@(negedge clock);
		hostRequest.writeEnable = 1'b0;
		idleGap();
	endtask

	// read data registered one edge after the address
	task automatic hostRead(input logic [15:0] address, output word32 data);
		@(negedge clock);
		hostRequest.writeEnable = 1'b0;
		hostRequest.address = address;
		@(negedge clock);
		data = hostData;
	endtask

	task automatic waitForBusy();
		int cycles;
		cycles = 0;
		while (busy !== 1'b1)
		begin
			if (cycles == 10)
				stopWithFailure("timeout: busy did not rise after start");
			cycles++;
			@(negedge clock);
		end
	endtask

	task automatic waitForDone(input int limit);
		int cycles;
		cycles = 0;
		while (done !== 1'b1)
		begin
			if (cycles == limit)
				stopWithFailure("timeout: done never came at the end of the subframe");
			cycles++;
			@(negedge clock);
		end
	endtask

	//////////////////////////////
	// one subframe record
	//////////////////////////////

	task automatic runRecord();
		codecParams_t next;
		logic [15:0] length;
		logic [15:0] excBase;
		logic [15:0] codeBase;
		int excAt;
		int codeAt;
		int expectAt;
		word32 readBack;
		next.gainPitch = stimulus[pointer][15:0];
		next.gainCode = stimulus[pointer + 1][15:0];
		next.sharpMin = stimulus[pointer + 2][15:0];
		next.sharpMax = stimulus[pointer + 3][15:0];
		next.subframeBase = stimulus[pointer + 4][15:0];
		next.subframeLength = stimulus[pointer + 5][15:0];
		next.codeBase = stimulus[pointer + 6][15:0];
		excBase = next.subframeBase;
		length = next.subframeLength;
		codeBase = next.codeBase;
		excAt = pointer + 8;
		codeAt = excAt + int'(length);
		expectAt = codeAt + int'(length);
		// guards on both sides of the exc region
		hostWrite(excBase - 16'd1, guardWord(excBase - 16'd1));
		hostWrite(excBase + length, guardWord(excBase + length));
		for (int i = 0; i < int'(length); i++)
			hostWrite(excBase + 16'(i), signExtend(stimulus[excAt + i]));
		for (int i = 0; i < int'(length); i++)
			hostWrite(codeBase + 16'(i), signExtend(stimulus[codeAt + i]));
		@(negedge clock);
		params = next;
		start = 1'b1;
		waitForBusy();
		start = 1'b0;
		// host write during the run must be dropped
		hostRequest.writeEnable = 1'b1;
		hostRequest.address = excBase + length;
		hostRequest.data = ~guardWord(excBase + length);
		@(negedge clock);
		hostRequest.writeEnable = 1'b0;
		waitForDone(10 * int'(length) + 20);
		checkValue("sharp", {16'h0000, sharp}, {16'h0000, stimulus[pointer + 7][15:0]});
		checkValue("busy", {31'd0, busy}, 32'd0);
		for (int i = 0; i < int'(length); i++)
		begin
			hostRead(excBase + 16'(i), readBack);
			checkValue($sformatf("exc word %h", excBase + 16'(i)), readBack,
				stimulus[expectAt + i]);
		end
		// code region and guards untouched
		for (int i = 0; i < int'(length); i++)
		begin
			hostRead(codeBase + 16'(i), readBack);
			checkValue($sformatf("code word %h", codeBase + 16'(i)), readBack,
				signExtend(stimulus[codeAt + i]));
		end
		hostRead(excBase - 16'd1, readBack);
		checkValue($sformatf("guard word %h", excBase - 16'd1), readBack,
			guardWord(excBase - 16'd1));
		hostRead(excBase + length, readBack);
		checkValue($sformatf("guard word %h", excBase + length), readBack,
			guardWord(excBase + length));
		pointer = expectAt + int'(length);
	endtask

	initial
	begin
		int records;
		int cycles;
		start = 1'b0;
		params = '0;
		hostRequest = '0;
		lfsrState = 32'h5a73;
		pointer = 1;
		$readmemh("sim/excUpdate_stimulus.txt", stimulus);
		if ($isunknown(stimulus[0]) || stimulus[0] == 32'd0)
			stopWithFailure("stimulus file sim/excUpdate_stimulus.txt holds no records");
		records = int'(stimulus[0]);
		cycles = 0;
		@(negedge clock);
		while (reset !== 1'b0)
		begin
			if (cycles == 20)
				stopWithFailure("timeout: reset was never released");
			cycles++;
			@(negedge clock);
		end
		repeat (records) runRecord();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== sim/excUpdate_props.sv ====
module excUpdate_props (
	input logic clock,
	input logic reset,
	input logic shiftReady,
	input logic shiftDone,
	input logic busy,
	input logic done,
	input logic writeEnable
);

	// ready held until the shifter answers
	assert property (@(posedge clock) disable iff (reset)
		shiftReady && !shiftDone |=> shiftReady)
		else $error("shiftReady dropped before shiftDone");

	// single-cycle done pulse
	assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
		else $error("done held for more than one cycle");

	// engine writes only inside a run
	assert property (@(posedge clock) disable iff (reset)
		writeEnable |-> busy)
		else $error("engine memory write while busy is low");

endmodule

bind excitationUpdate excUpdate_props excUpdateProps_i (
	.clock(clock),
	.reset(reset),
	.shiftReady(shiftReady),
	.shiftDone(shiftDone),
	.busy(busy),
	.done(done),
	.writeEnable(memRequest.writeEnable)
);

// ==== sim/clockGen.sv ====
module clockGen #(
	parameter int period = 40,
	parameter int resetCycles = 5
) (
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// synchronous reset, released on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

// ==== rtl/excUpdateTop.sv ====
module excUpdateTop #(
	parameter int addrWidth = 12
) (
	input logic clock,
	input logic reset,
	input logic start,
	input excUpdatePkg::codecParams_t params,
	input excUpdatePkg::memRequest_t hostRequest,
	output excUpdatePkg::word32 hostData,
	output logic busy,
	output logic done,
	output excUpdatePkg::word16 sharp
);
	import excUpdatePkg::*;

	// engine to operator block
	opRequest_t opRequest;
	opResult_t opResult;
	// engine to shifter handshake
	shiftRequest_t shiftRequest;
	logic shiftReady;
	logic shiftDone;
	word32 shiftResult;
	// engine side of the scratch port
	memRequest_t engineRequest;
	word32 engineData;

	excitationUpdate #(
		.addrWidth(addrWidth)
	) excitationUpdate_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.params(params),
		.opRequest(opRequest),
		.opResult(opResult),
		.shiftRequest(shiftRequest),
		.shiftReady(shiftReady),
		.shiftResult(shiftResult),
		.shiftDone(shiftDone),
		.memRequest(engineRequest),
		.memData(engineData),
		.busy(busy),
		.done(done),
		.sharp(sharp)
	);

	// shared saturating arithmetic
	basicOps basicOps_i (
		.request(opRequest),
		.result(opResult)
	);

	longShifter longShifter_i (
		.clock(clock),
		.reset(reset),
		.ready(shiftReady),
		.request(shiftRequest),
		.done(shiftDone),
		.result(shiftResult)
	);

	// host served only while busy is low
	scratchMemory #(
		.addrWidth(addrWidth)
	) scratchMemory_i (
		.clock(clock),
		.engineRequest(engineRequest),
		.engineData(engineData),
		.hostRequest(hostRequest),
		.hostData(hostData),
		.engineBusy(busy)
	);

endmodule

// ==== rtl/excitationUpdate.sv ====
module excitationUpdate #(
	parameter int addrWidth = 12
) (
	input logic clock,
	input logic reset,
	input logic start,
	input excUpdatePkg::codecParams_t params,
	output excUpdatePkg::opRequest_t opRequest,
	input excUpdatePkg::opResult_t opResult,
	output excUpdatePkg::shiftRequest_t shiftRequest,
	output logic shiftReady,
	input excUpdatePkg::word32 shiftResult,
	input logic shiftDone,
	output excUpdatePkg::memRequest_t memRequest,
	input excUpdatePkg::word32 memData,
	output logic busy,
	output logic done,
	output excUpdatePkg::word16 sharp
);
	import excUpdatePkg::*;

	// keeps addresses inside the scratch array
	localparam logic [15:0] addrMask = 16'((32'd1 << addrWidth) - 1);

	typedef enum logic [3:0] {
		idle, clampHigh, clampLow, loopTest, readCode,
		accumulate, shift, round, writeBack, finish
	} state_t;

	state_t state;
	codecParams_t saved;
	// sample index i
	logic [15:0] index;
	logic [15:0] excAddress;
	logic [15:0] codeAddress;
	word32 acc;
	word16 rounded;

	//////////////////////////////
	// operator and port requests
	//////////////////////////////

	always_comb
	begin
		opRequest = '0;
		memRequest = '0;
		// L_shl(L_temp, 1)
		shiftRequest.value = acc;
		shiftRequest.count = 16'sd1;
		shiftReady = (state == shift);
		busy = (state != idle) && (state != finish);
		done = (state == finish);
		case (state)
			// sub(gainPitch, sharpMax)
			clampHigh:
			begin
				opRequest.op = opSub;
				opRequest.a = {16'h0000, saved.gainPitch};
				opRequest.b = saved.sharpMax;
			end
			// sub(sharp, sharpMin)
			clampLow:
			begin
				opRequest.op = opSub;
				opRequest.a = {16'h0000, sharp};
				opRequest.b = saved.sharpMin;
			end
			// exc[i+subframeBase] read
			loopTest:
			begin
				opRequest.op = opLAdd;
				opRequest.a = {16'h0000, index};
				opRequest.c = {16'h0000, saved.subframeBase};
				memRequest.address = opResult.long[15:0] & addrMask;
			end
			// L_mult(exc, gainPitch), code[i] read
			readCode:
			begin
				opRequest.op = opLMult;
				opRequest.a = {16'h0000, memData[15:0]};
				opRequest.b = saved.gainPitch;
				memRequest.address = codeAddress;
			end
			// L_mac(acc, code, gainCode)
			accumulate:
			begin
				opRequest.op = opLMac;
				opRequest.a = {16'h0000, memData[15:0]};
				opRequest.b = saved.gainCode;
				opRequest.c = acc;
			end
			// i++ taken on the shifter done cycle
			shift:
			begin
				opRequest.op = opAdd;
				opRequest.a = {16'h0000, index};
				opRequest.b = 16'sd1;
			end
			round:
			begin
				opRequest.op = opLAdd;
				opRequest.a = acc;
				opRequest.c = roundBias;
			end
			// store sign-extended, next code address
			writeBack:
			begin
				opRequest.op = opAdd;
				opRequest.a = {16'h0000, saved.codeBase};
				opRequest.b = index;
				memRequest.writeEnable = 1'b1;
				memRequest.address = excAddress;
				memRequest.data = {{16{rounded[15]}}, rounded};
			end
			default:
				opRequest.op = opNone;
		endcase
	end

	//////////////////////////////
	// state sequence
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= idle;
		else
		begin
			case (state)
				idle:
					if (start)
						state <= clampHigh;
				clampHigh:
					state <= clampLow;
				// zero length skips the loop
				clampLow:
					state <= (saved.subframeLength != 16'd0) ? loopTest : finish;
				loopTest:
					state <= readCode;
				readCode:
					state <= accumulate;
				accumulate:
					state <= shift;
				shift:
					if (shiftDone)
						state <= round;
				round:
					state <= writeBack;
				// index already advanced in shift
				writeBack:
					state <= (index < saved.subframeLength) ? loopTest : finish;
				default:
					state <= idle;
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge clock)
	begin
		case (state)
			idle:
				if (start)
				begin
					saved <= params;
					index <= 16'd0;
					codeAddress <= params.codeBase & addrMask;
				end
			// above max when the difference is positive
			clampHigh:
				sharp <= (!opResult.short[15] && opResult.short != 16'sd0) ?
					saved.sharpMax : saved.gainPitch;
			clampLow:
				if (opResult.short[15])
					sharp <= saved.sharpMin;
			loopTest:
				excAddress <= opResult.long[15:0] & addrMask;
			readCode:
				acc <= opResult.long;
			accumulate:
				acc <= opResult.long;
			shift:
				if (shiftDone)
				begin
					acc <= shiftResult;
					index <= opResult.short;
				end
			// upper word of the biased value
			round:
				rounded <= opResult.long[31:16];
			writeBack:
				codeAddress <= opResult.short & addrMask;
			default:
				rounded <= rounded;
		endcase
	end

endmodule

// ==== rtl/scratchMemory.sv ====
module scratchMemory #(
	parameter int addrWidth = 12
) (
	input logic clock,
	input excUpdatePkg::memRequest_t engineRequest,
	output excUpdatePkg::word32 engineData,
	input excUpdatePkg::memRequest_t hostRequest,
	output excUpdatePkg::word32 hostData,
	input logic engineBusy
);
	import excUpdatePkg::*;

	localparam int depth = 1 << addrWidth;

	word32 storage [depth];
	// whichever side owns the single port this cycle
	memRequest_t owner;
	logic [addrWidth-1:0] wordAddress;
	word32 readWord;

	// engine owns the port for the whole run, host is locked out
	assign owner = engineBusy ? engineRequest : hostRequest;
	assign wordAddress = owner.address[addrWidth-1:0];

	//////////////////////////////
	// single port array
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (owner.writeEnable)
			storage[wordAddress] <= owner.data;
		// read before write on the same address
		readWord <= storage[wordAddress];
	end

	// one read register, both sides see it a cycle later
	assign engineData = readWord;
	assign hostData = readWord;

endmodule

// ==== rtl/longShifter.sv ====
module longShifter (
	input logic clock,
	input logic reset,
	input logic ready,
	input excUpdatePkg::shiftRequest_t request,
	output logic done,
	output excUpdatePkg::word32 result
);
	import excUpdatePkg::*;

	logic active;
	logic shiftLeft;
	// shift positions still to apply
	logic [15:0] remaining;
	word32 value;
	word32 stepped;

	// one position, left saturates on overflow
	function automatic word32 shiftOnce(input word32 v, input logic left);
		if (!left)
			return v >>> 1;
		if (v[31] != v[30])
			return v[31] ? 32'sh80000000 : 32'sh7fffffff;
		return v <<< 1;
	endfunction

	assign stepped = shiftOnce(value, shiftLeft);

	// last position is applied on the done cycle itself
	assign done = active && (remaining <= 16'd1);
	assign result = (remaining == 16'd0) ? value : stepped;

	always_ff @(posedge clock)
	begin
		if (reset)
			active <= 1'b0;
		else if (!active)
			active <= ready;
		else if (done)
			active <= 1'b0;
	end

	// request latched while idle, then stepped once per cycle
	always_ff @(posedge clock)
	begin
		if (!active && ready)
		begin
			value <= request.value;
			shiftLeft <= !request.count[15];
			remaining <= request.count[15] ? 16'(-request.count) : request.count;
		end
		else if (active && remaining > 16'd1)
		begin
			value <= stepped;
			remaining <= remaining - 16'd1;
		end
	end

endmodule

// ==== rtl/basicOps.sv ====
module basicOps (
	input excUpdatePkg::opRequest_t request,
	output excUpdatePkg::opResult_t result
);
	import excUpdatePkg::*;

	// low half of operand a, used by the 16-bit ops
	word16 shortA;

	//////////////////////////////
	// saturating helpers
	//////////////////////////////

	// 17-bit sum down to q15
	function automatic word16 saturate16(input logic [16:0] wide);
		// overflow when the two top bits disagree
		if (wide[16] != wide[15])
			return wide[16] ? 16'sh8000 : 16'sh7fff;
		return wide[15:0];
	endfunction

	// L_add
	function automatic word32 lAdd(input word32 x, input word32 y);
		logic [32:0] wide;
		wide = {x[31], x} + {y[31], y};
		if (wide[32] != wide[31])
			return wide[32] ? 32'sh80000000 : 32'sh7fffffff;
		return wide[31:0];
	endfunction

	// L_mult, product doubled into q31
	function automatic word32 lMult(input word16 x, input word16 y);
		word32 product;
		product = x * y;
		// -1 * -1 is the only case that overflows
		if (x == 16'sh8000 && y == 16'sh8000)
			return 32'sh7fffffff;
		return product <<< 1;
	endfunction

	assign shortA = request.a[15:0];

	//////////////////////////////
	// opcode decode
	//////////////////////////////

	always_comb
	begin
		// opNone leaves both fields at zero
		result = '0;
		case (request.op)
			opAdd:
				result.short = saturate16({shortA[15], shortA} + {request.b[15], request.b});
			opSub:
				result.short = saturate16({shortA[15], shortA} - {request.b[15], request.b});
			opLAdd:
				result.long = lAdd(request.a, request.c);
			opLMult:
				result.long = lMult(shortA, request.b);
			// accumulator rides on c
			opLMac:
				result.long = lAdd(request.c, lMult(shortA, request.b));
			default:
				result = '0;
		endcase
	end

endmodule

// ==== rtl/excUpdatePkg.sv ====
package excUpdatePkg;

	//////////////////////////////
	// data words
	//////////////////////////////

	// q15 sample word
	typedef logic signed [15:0] word16;
	// q31 accumulator word
	typedef logic signed [31:0] word32;

	// basic operator selection
	typedef enum logic [2:0] {
		opNone,
		opAdd,
		opSub,
		opLAdd,
		opLMult,
		opLMac
	} opcode_t;

	//////////////////////////////
	// block requests and results
	//////////////////////////////

	// a is 32 bits for L_add and L_mac, low half used otherwise
	typedef struct packed {
		opcode_t op;
		word32 a;
		word16 b;
		word32 c;
	} opRequest_t;

	// short for add/sub, long for the 32-bit ops
	typedef struct packed {
		word16 short;
		word32 long;
	} opResult_t;

	// positive count shifts left
	typedef struct packed {
		word32 value;
		logic signed [15:0] count;
	} shiftRequest_t;

	// only the low addrWidth address bits reach the memory
	typedef struct packed {
		logic writeEnable;
		logic [15:0] address;
		word32 data;
	} memRequest_t;

	// half an lsb of the upper word, for round()
	localparam word32 roundBias = 32'sh00008000;

	// per-subframe inputs
	typedef struct packed {
		word16 gainPitch;
		word16 gainCode;
		word16 sharpMin;
		word16 sharpMax;
		logic [15:0] subframeBase;
		logic [15:0] subframeLength;
		logic [15:0] codeBase;
	} codecParams_t;

endpackage
